/* verilog/mipsPkg.sv */
package mipsPkg;

   // Datapath words and instruction words
   typedef logic [31:0] word_t;
   typedef logic [31:0] instr_t;

   // Register number and decode fields
   typedef logic [4:0] regAddr_t;
   typedef logic [5:0] opcode_t;
   typedef logic [5:0] funct_t;

   // ALU operation select and forwarding select
   typedef logic [3:0] aluCtl_t;
   typedef logic [1:0] fwdSel_t;

   // Major opcodes, MIPS encoding
   parameter opcode_t opR    = 6'd0;
   parameter opcode_t opLw   = 6'd35;
   parameter opcode_t opSw   = 6'd43;
   parameter opcode_t opBeq  = 6'd4;
   parameter opcode_t opAddi = 6'd8;

   // R-type function codes
   parameter funct_t fnAdd = 6'd32;
   parameter funct_t fnSub = 6'd34;
   parameter funct_t fnAnd = 6'd36;
   parameter funct_t fnOr  = 6'd37;
   parameter funct_t fnSlt = 6'd42;

   // ALU control codes
   parameter aluCtl_t aluAnd = 4'd0;
   parameter aluCtl_t aluOr  = 4'd1;
   parameter aluCtl_t aluAdd = 4'd2;
   parameter aluCtl_t aluSub = 4'd6;
   parameter aluCtl_t aluSlt = 4'd7;

   // Operand source for EX
   parameter fwdSel_t fwdNone = 2'd0;
   parameter fwdSel_t fwdWb   = 2'd1;
   parameter fwdSel_t fwdMem  = 2'd2;

   // Low bit of rs, rt and rd in the instruction
   parameter int rsLsb = 21;
   parameter int rtLsb = 16;
   parameter int rdLsb = 11;

endpackage

/* verilog/fetchStage.sv */
`timescale 1ns/1ns
module fetchStage #(
   parameter int imemWords = 64
) (
   input  logic            Clk,
   input  logic            arstN,
   input  logic            run,
   input  logic            stall,
   input  logic            flush,
   input  logic            branchTaken,
   input  mipsPkg::word_t  branchTarget,
   input  logic            progWe,
   input  mipsPkg::word_t  progAddr,
   input  mipsPkg::instr_t progData,
   output mipsPkg::instr_t idInstr,
   output mipsPkg::word_t  idPcPlus4
);
   localparam int addrBits = $clog2(imemWords);

   mipsPkg::word_t  pc;
   mipsPkg::word_t  pcPlus4;
   mipsPkg::instr_t fetchInstr;
   mipsPkg::instr_t imem [imemWords];
   logic [imemWords-1:0] wordLoaded;
   logic [addrBits-1:0]  progIdx;
   logic [addrBits-1:0]  pcIdx;

   assign progIdx = progAddr[addrBits-1:0];
   // Byte PC, word-indexed memory
   assign pcIdx   = pc[addrBits+1:2];
   assign pcPlus4 = pc + 32'd4;

   // Program load port, one word per strobe
   always_ff @(posedge Clk) begin
      if (progWe) begin
         imem[progIdx] <= progData;
      end
   end

   // Words never written read back as zero
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         wordLoaded <= '0;
      end else if (progWe) begin
         wordLoaded[progIdx] <= 1'b1;
      end
   end

   assign fetchInstr = wordLoaded[pcIdx] ? imem[pcIdx] : '0;

   // Taken branch wins over a load-use hold
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (!run) begin
         pc <= '0;
      end else if (branchTaken) begin
         pc <= branchTarget;
      end else if (!stall) begin
         pc <= pcPlus4;
      end
   end

   // IF/ID, bubble while idle or squashed
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         idInstr   <= '0;
         idPcPlus4 <= '0;
      end else if (!run || flush) begin
         idInstr   <= '0;
         idPcPlus4 <= '0;
      end else if (!stall) begin
         idInstr   <= fetchInstr;
         idPcPlus4 <= pcPlus4;
      end
   end

endmodule

/* verilog/decodeStage.sv */
`timescale 1ns/1ns
module decodeStage (
   input  logic             Clk,
   input  logic             arstN,
   input  mipsPkg::instr_t  idInstr,
   input  mipsPkg::word_t   idPcPlus4,
   input  logic             stall,
   input  logic             flush,
   input  logic             wbValid,
   input  mipsPkg::regAddr_t wbReg,
   input  mipsPkg::word_t   wbData,
   output logic             exRegWrite,
   output logic             exMemToReg,
   output logic             exMemRead,
   output logic             exMemWrite,
   output logic             exBranch,
   output logic             exAluSrc,
   output logic             exRegDst,
   output logic [1:0]       exAluOp,
   output mipsPkg::word_t   exRs1Data,
   output mipsPkg::word_t   exRs2Data,
   output mipsPkg::word_t   exImm,
   output mipsPkg::word_t   exPcPlus4,
   output mipsPkg::instr_t  exInstr
);
   mipsPkg::opcode_t  opcode;
   mipsPkg::regAddr_t rs;
   mipsPkg::regAddr_t rt;
   mipsPkg::word_t    regs [32];
   mipsPkg::word_t    rs1Data;
   mipsPkg::word_t    rs2Data;
   mipsPkg::word_t    imm;
   logic regWrite, memToReg, memRead, memWrite, branch, aluSrc, regDst;
   logic [1:0] aluOp;
   logic bubble;

   assign opcode = idInstr[31:26];
   assign rs     = idInstr[mipsPkg::rsLsb +: 5];
   assign rt     = idInstr[mipsPkg::rtLsb +: 5];
   assign imm    = {{16{idInstr[15]}}, idInstr[15:0]};
   assign bubble = stall || flush;

   // Main control
   // aluOp 00 add, 01 subtract for beq, 10 by funct
   always_comb begin
      {regWrite, memToReg, memRead, memWrite} = 4'b0000;
      {branch, aluSrc, regDst} = 3'b000;
      aluOp = 2'b00;
      case (opcode)
         mipsPkg::opR: begin
            regWrite = 1'b1;
            regDst   = 1'b1;
            aluOp    = 2'b10;
         end
         mipsPkg::opLw: begin
            regWrite = 1'b1;
            memToReg = 1'b1;
            memRead  = 1'b1;
            aluSrc   = 1'b1;
         end
         mipsPkg::opSw: begin
            memWrite = 1'b1;
            aluSrc   = 1'b1;
         end
         mipsPkg::opBeq: begin
            branch = 1'b1;
            aluOp  = 2'b01;
         end
         mipsPkg::opAddi: begin
            regWrite = 1'b1;
            aluSrc   = 1'b1;
         end
         default: ;
      endcase
   end

   // Register file, written by WB at the clock edge
   // wbValid never set for r0, so r0 stays zero
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wbValid) begin
         regs[wbReg] <= wbData;
      end
   end

   // Same-cycle write shows up on the read side
   assign rs1Data = (wbValid && wbReg == rs) ? wbData : regs[rs];
   assign rs2Data = (wbValid && wbReg == rt) ? wbData : regs[rt];

   // ID/EX, stall or flush turns the slot into a bubble
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         {exRegWrite, exMemToReg, exMemRead, exMemWrite} <= 4'b0000;
         {exBranch, exAluSrc, exRegDst} <= 3'b000;
         exAluOp   <= 2'b00;
         exRs1Data <= '0;
         exRs2Data <= '0;
         exImm     <= '0;
         exPcPlus4 <= '0;
         exInstr   <= '0;
      end else begin
         if (bubble) begin
            {exRegWrite, exMemToReg, exMemRead, exMemWrite} <= 4'b0000;
            {exBranch, exAluSrc, exRegDst} <= 3'b000;
            exAluOp <= 2'b00;
         end else begin
            {exRegWrite, exMemToReg, exMemRead, exMemWrite} <=
               {regWrite, memToReg, memRead, memWrite};
            {exBranch, exAluSrc, exRegDst} <= {branch, aluSrc, regDst};
            exAluOp <= aluOp;
         end
         exRs1Data <= rs1Data;
         exRs2Data <= rs2Data;
         exImm     <= imm;
         exPcPlus4 <= idPcPlus4;
         exInstr   <= idInstr;
      end
   end

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/1ns
module hazardUnit (
   input  mipsPkg::regAddr_t idRs,
   input  mipsPkg::regAddr_t idRt,
   input  mipsPkg::instr_t   exInstr,
   input  logic              exMemRead,
   input  logic              exRegWrite,
   input  logic              memRegWrite,
   input  mipsPkg::regAddr_t memDest,
   input  logic              wbValid,
   input  mipsPkg::regAddr_t wbReg,
   input  logic              branchTaken,
   output mipsPkg::fwdSel_t  fwdA,
   output mipsPkg::fwdSel_t  fwdB,
   output logic              stall,
   output logic              flush
);
   mipsPkg::regAddr_t exRs;
   mipsPkg::regAddr_t exRt;

   assign exRs = exInstr[mipsPkg::rsLsb +: 5];
   assign exRt = exInstr[mipsPkg::rtLsb +: 5];

   // Youngest producer first
   // nonzero destination keeps r0 from forwarding
   function automatic mipsPkg::fwdSel_t pickFwd(input mipsPkg::regAddr_t src);
      if (memRegWrite && memDest != '0 && memDest == src) begin
         return mipsPkg::fwdMem;
      end else if (wbValid && wbReg == src) begin
         return mipsPkg::fwdWb;
      end
      return mipsPkg::fwdNone;
   endfunction

   always_comb begin
      fwdA = pickFwd(exRs);
      fwdB = pickFwd(exRt);
   end

   // Load in EX feeding the instruction in ID
   // data only exists after MEM, so hold one cycle
   assign stall = exMemRead && exRegWrite && exRt != '0 && (exRt == idRs || exRt == idRt);

   // Taken beq squashes IF/ID and ID/EX
   assign flush = branchTaken;

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ns
module executeStage (
   input  logic              Clk,
   input  logic              arstN,
   input  logic              exRegWrite,
   input  logic              exMemToReg,
   input  logic              exMemRead,
   input  logic              exMemWrite,
   input  logic              exBranch,
   input  logic              exAluSrc,
   input  logic              exRegDst,
   input  logic [1:0]        exAluOp,
   input  mipsPkg::word_t    exRs1Data,
   input  mipsPkg::word_t    exRs2Data,
   input  mipsPkg::word_t    exImm,
   input  mipsPkg::word_t    exPcPlus4,
   input  mipsPkg::instr_t   exInstr,
   input  mipsPkg::fwdSel_t  fwdA,
   input  mipsPkg::fwdSel_t  fwdB,
   input  mipsPkg::word_t    wbData,
   output logic              branchTaken,
   output mipsPkg::word_t    branchTarget,
   output logic              memRegWrite,
   output logic              memMemToReg,
   output logic              memMemRead,
   output logic              memMemWrite,
   output mipsPkg::word_t    memAluResult,
   output mipsPkg::word_t    memStoreData,
   output mipsPkg::regAddr_t memDest
);
   mipsPkg::word_t    opA;
   mipsPkg::word_t    opB;
   mipsPkg::word_t    aluB;
   mipsPkg::word_t    aluResult;
   mipsPkg::aluCtl_t  aluCtl;
   mipsPkg::funct_t   funct;
   mipsPkg::regAddr_t dest;
   logic zero;

   // Operand source picked by the hazard unit
   // EX/MEM result comes from this stage's own register
   function automatic mipsPkg::word_t fwdMux(input mipsPkg::fwdSel_t sel,
                                             input mipsPkg::word_t regVal);
      case (sel)
         mipsPkg::fwdMem: return memAluResult;
         mipsPkg::fwdWb:  return wbData;
         default:         return regVal;
      endcase
   endfunction

   always_comb begin
      opA = fwdMux(fwdA, exRs1Data);
      opB = fwdMux(fwdB, exRs2Data);
   end

   assign aluB  = exAluSrc ? exImm : opB;
   assign funct = exInstr[5:0];

   // ALU control
   always_comb begin
      case (exAluOp)
         2'b00: aluCtl = mipsPkg::aluAdd;
         2'b01: aluCtl = mipsPkg::aluSub;
         default: begin
            case (funct)
               mipsPkg::fnSub: aluCtl = mipsPkg::aluSub;
               mipsPkg::fnAnd: aluCtl = mipsPkg::aluAnd;
               mipsPkg::fnOr:  aluCtl = mipsPkg::aluOr;
               mipsPkg::fnSlt: aluCtl = mipsPkg::aluSlt;
               // add, and funct 0 of an empty word
               default:        aluCtl = mipsPkg::aluAdd;
            endcase
         end
      endcase
   end

   always_comb begin
      case (aluCtl)
         mipsPkg::aluAnd: aluResult = opA & aluB;
         mipsPkg::aluOr:  aluResult = opA | aluB;
         mipsPkg::aluSub: aluResult = opA - aluB;
         mipsPkg::aluSlt: aluResult = {31'd0, $signed(opA) < $signed(aluB)};
         default:         aluResult = opA + aluB;
      endcase
   end

   assign zero = (aluResult == '0);

   // Branch resolved here, offset counts words
   assign branchTaken  = exBranch && zero;
   assign branchTarget = exPcPlus4 + {exImm[29:0], 2'b00};

   // rd for R-type, rt otherwise
   assign dest = exRegDst ? exInstr[mipsPkg::rdLsb +: 5] : exInstr[mipsPkg::rtLsb +: 5];

   // EX/MEM
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         {memRegWrite, memMemToReg, memMemRead, memMemWrite} <= 4'b0000;
         memAluResult <= '0;
         memStoreData <= '0;
         memDest      <= '0;
      end else begin
         {memRegWrite, memMemToReg, memMemRead, memMemWrite} <=
            {exRegWrite, exMemToReg, exMemRead, exMemWrite};
         memAluResult <= aluResult;
         // Store data after forwarding
         memStoreData <= opB;
         memDest      <= dest;
      end
   end

endmodule

/* verilog/memoryStage.sv */
`timescale 1ns/1ns
module memoryStage #(
   parameter int dmemWords = 64
) (
   input  logic              Clk,
   input  logic              arstN,
   input  logic              memRegWrite,
   input  logic              memMemToReg,
   input  logic              memMemRead,
   input  logic              memMemWrite,
   input  mipsPkg::word_t    memAluResult,
   input  mipsPkg::word_t    memStoreData,
   input  mipsPkg::regAddr_t memDest,
   output logic              wbValid,
   output mipsPkg::regAddr_t wbReg,
   output mipsPkg::word_t    wbData,
   output logic              storeValid,
   output mipsPkg::word_t    storeAddr,
   output mipsPkg::word_t    storeData
);
   localparam int addrBits = $clog2(dmemWords);

   mipsPkg::word_t dmem [dmemWords];
   mipsPkg::word_t loadData;
   logic [addrBits-1:0] wordIdx;

   // Byte address to word index
   assign wordIdx = memAluResult[addrBits+1:2];

   always_ff @(posedge Clk) begin
      if (memMemWrite) begin
         dmem[wordIdx] <= memStoreData;
      end
   end

   // Async read, only for lw
   assign loadData = memMemRead ? dmem[wordIdx] : '0;

   // Store stream, same cycle as the write
   assign storeValid = memMemWrite;
   assign storeAddr  = memAluResult;
   assign storeData  = memStoreData;

   // MEM/WB with writeback mux in front
   // writes to r0 never retire as a writeback
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         wbValid <= 1'b0;
         wbReg   <= '0;
         wbData  <= '0;
      end else begin
         wbValid <= memRegWrite && memDest != '0;
         wbReg   <= memDest;
         wbData  <= memMemToReg ? loadData : memAluResult;
      end
   end

endmodule

/* verilog/mips32.sv */
`timescale 1ns/1ns
module mips32 #(
   parameter int imemWords = 64,
   parameter int dmemWords = 64
) (
   input  logic              Clk,
   input  logic              arstN,
   input  logic              run,
   input  logic              progWe,
   input  mipsPkg::word_t    progAddr,
   input  mipsPkg::instr_t   progData,
   output logic              wbValid,
   output mipsPkg::regAddr_t wbReg,
   output mipsPkg::word_t    wbData,
   output logic              storeValid,
   output mipsPkg::word_t    storeAddr,
   output mipsPkg::word_t    storeData
);
   // IF/ID
   mipsPkg::instr_t idInstr;
   mipsPkg::word_t  idPcPlus4;
   // ID/EX
   logic exRegWrite, exMemToReg, exMemRead, exMemWrite, exBranch, exAluSrc, exRegDst;
   logic [1:0] exAluOp;
   mipsPkg::word_t  exRs1Data, exRs2Data, exImm, exPcPlus4;
   mipsPkg::instr_t exInstr;
   // EX/MEM
   logic memRegWrite, memMemToReg, memMemRead, memMemWrite;
   mipsPkg::word_t    memAluResult, memStoreData;
   mipsPkg::regAddr_t memDest;
   // Hazard and branch
   mipsPkg::fwdSel_t fwdA, fwdB;
   logic stall, flush, branchTaken;
   mipsPkg::word_t branchTarget;

   fetchStage #(.imemWords(imemWords)) fetch (
      .Clk, .arstN, .run, .stall, .flush, .branchTaken, .branchTarget,
      .progWe, .progAddr, .progData, .idInstr, .idPcPlus4
   );

   decodeStage decode (
      .Clk, .arstN, .idInstr, .idPcPlus4, .stall, .flush, .wbValid, .wbReg, .wbData,
      .exRegWrite, .exMemToReg, .exMemRead, .exMemWrite, .exBranch, .exAluSrc,
      .exRegDst, .exAluOp, .exRs1Data, .exRs2Data, .exImm, .exPcPlus4, .exInstr
   );

   hazardUnit hazard (
      .idRs(idInstr[mipsPkg::rsLsb +: 5]), .idRt(idInstr[mipsPkg::rtLsb +: 5]),
      .exInstr, .exMemRead, .exRegWrite, .memRegWrite, .memDest, .wbValid, .wbReg,
      .branchTaken, .fwdA, .fwdB, .stall, .flush
   );

   executeStage execute (
      .Clk, .arstN, .exRegWrite, .exMemToReg, .exMemRead, .exMemWrite, .exBranch,
      .exAluSrc, .exRegDst, .exAluOp, .exRs1Data, .exRs2Data, .exImm, .exPcPlus4,
      .exInstr, .fwdA, .fwdB, .wbData, .branchTaken, .branchTarget, .memRegWrite,
      .memMemToReg, .memMemRead, .memMemWrite, .memAluResult, .memStoreData, .memDest
   );

   memoryStage #(.dmemWords(dmemWords)) memory (
      .Clk, .arstN, .memRegWrite, .memMemToReg, .memMemRead, .memMemWrite,
      .memAluResult, .memStoreData, .memDest, .wbValid, .wbReg, .wbData,
      .storeValid, .storeAddr, .storeData
   );

endmodule

/* tests/mips32_checker.sv */
`timescale 1ns/1ns
module mips32Checker (
   input logic              Clk,
   input logic              arstN,
   input logic              wbValid,
   input mipsPkg::regAddr_t wbReg,
   input mipsPkg::word_t    wbData,
   input logic              storeValid,
   input mipsPkg::word_t    storeAddr,
   input mipsPkg::word_t    storeData
);

   // Retiring write always names a real register
   wbNotR0: assert property (@(posedge Clk) disable iff (!arstN) wbValid |-> wbReg != '0)
      else $error("writeback strobe names register zero");

   // Both strobes quiet in reset
   quietInReset: assert property (@(posedge Clk) !arstN |-> !wbValid && !storeValid)
      else $error("output strobe high during reset");

   // Outputs settled one cycle out of reset
   knownAfterReset: assert property (@(posedge Clk) $rose(arstN) |=>
      !$isunknown({wbValid, wbReg, wbData, storeValid, storeAddr, storeData}))
      else $error("unknown output value right after reset");

endmodule

bind mips32 mips32Checker outputCheck (
   .Clk, .arstN, .wbValid, .wbReg, .wbData, .storeValid, .storeAddr, .storeData
);

/* tests/mips32Tb.sv */
`timescale 1ns/1ns
module mips32Tb;

   localparam int imemWords = 64;
   localparam int dmemWords = 64;
   localparam int memIdxBits = $clog2(dmemWords);
   localparam int testCount = 5;
   // Every test loads the whole instruction memory
   localparam int watchdogCycles = testCount * (20 * imemWords + 200);
   // Must stay below the PC wrap at imemWords fetches
   localparam int retireWindow = 54;
   localparam int extraWindow = 6;

   logic              Clk;
   logic              arstN;
   logic              run;
   logic              progWe;
   mipsPkg::word_t    progAddr;
   mipsPkg::instr_t   progData;
   logic              wbValid;
   mipsPkg::regAddr_t wbReg;
   mipsPkg::word_t    wbData;
   logic              storeValid;
   mipsPkg::word_t    storeAddr;
   mipsPkg::word_t    storeData;

   // Program of the current test
   mipsPkg::instr_t   prog[$];
   // Architectural state of the reference model, kept across tests like the DUT
   mipsPkg::word_t    modelRegs [32];
   mipsPkg::word_t    modelMem [dmemWords];
   // Expected event streams
   mipsPkg::regAddr_t expWbReg[$];
   mipsPkg::word_t    expWbData[$];
   mipsPkg::word_t    expStAddr[$];
   mipsPkg::word_t    expStData[$];
   // Observed event streams
   mipsPkg::regAddr_t gotWbReg[$];
   mipsPkg::word_t    gotWbData[$];
   mipsPkg::word_t    gotStAddr[$];
   mipsPkg::word_t    gotStData[$];
   int wbErrors;
   int storeErrors;
   int otherErrors;
   logic [31:0] rngState;

   mips32 #(.imemWords(imemWords), .dmemWords(dmemWords)) dut (
      .Clk, .arstN, .run, .progWe, .progAddr, .progData,
      .wbValid, .wbReg, .wbData, .storeValid, .storeAddr, .storeData
   );

   always #10 Clk = ~Clk;

   // Outputs sampled mid-cycle, well away from the rising edge
   always @(negedge Clk) begin
      if (wbValid) begin
         gotWbReg.push_back(wbReg);
         gotWbData.push_back(wbData);
      end
      if (storeValid) begin
         gotStAddr.push_back(storeAddr);
         gotStData.push_back(storeData);
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Maps a random byte onto r1..r7
   function automatic mipsPkg::regAddr_t regPick(input logic [7:0] x);
      return 5'(x % 8'd7) + 5'd1;
   endfunction

   task automatic emitR(input mipsPkg::funct_t fn, input mipsPkg::regAddr_t rd,
                        input mipsPkg::regAddr_t rs, input mipsPkg::regAddr_t rt);
      prog.push_back({mipsPkg::opR, rs, rt, rd, 5'd0, fn});
   endtask

   task automatic emitI(input mipsPkg::opcode_t op, input mipsPkg::regAddr_t rt,
                        input mipsPkg::regAddr_t rs, input logic [15:0] imm);
      prog.push_back({op, rs, rt, imm});
   endtask

   task automatic emitNops(input int n);
      repeat (n) prog.push_back('0);
   endtask

   // Sequential MIPS semantics, one instruction at a time
   task automatic modelRun();
      int pc;
      int steps;
      mipsPkg::instr_t   ins;
      mipsPkg::opcode_t  op;
      mipsPkg::funct_t   fn;
      mipsPkg::regAddr_t rs;
      mipsPkg::regAddr_t rt;
      mipsPkg::regAddr_t dst;
      mipsPkg::word_t    a;
      mipsPkg::word_t    b;
      mipsPkg::word_t    imm;
      mipsPkg::word_t    addr;
      mipsPkg::word_t    res;
      logic writes;
      pc = 0;
      steps = 0;
      while (pc < prog.size() && steps < 200) begin
         ins = prog[pc];
         op = ins[31:26];
         rs = ins[25:21];
         rt = ins[20:16];
         fn = ins[5:0];
         imm = {{16{ins[15]}}, ins[15:0]};
         a = modelRegs[rs];
         b = modelRegs[rt];
         dst = ins[15:11];
         res = '0;
         writes = 1'b0;
         pc = pc + 1;
         steps = steps + 1;
         if (op == mipsPkg::opR) begin
            writes = 1'b1;
            case (fn)
               mipsPkg::fnAdd: res = a + b;
               mipsPkg::fnSub: res = a - b;
               mipsPkg::fnAnd: res = a & b;
               mipsPkg::fnOr:  res = a | b;
               mipsPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               // Empty word and unused functs act as nops
               default:        writes = 1'b0;
            endcase
         end else if (op == mipsPkg::opAddi) begin
            writes = 1'b1;
            dst = rt;
            res = a + imm;
         end else if (op == mipsPkg::opLw) begin
            addr = a + imm;
            writes = 1'b1;
            dst = rt;
            res = modelMem[addr[memIdxBits+1:2]];
         end else if (op == mipsPkg::opSw) begin
            addr = a + imm;
            modelMem[addr[memIdxBits+1:2]] = b;
            expStAddr.push_back(addr);
            expStData.push_back(b);
         end else if (op == mipsPkg::opBeq) begin
            // Offset in words past the delay-free next instruction
            if (a == b) pc = pc + int'($signed(imm));
         end
         // r0 writes are dropped and never retire
         if (writes && dst != 5'd0) begin
            modelRegs[dst] = res;
            expWbReg.push_back(dst);
            expWbData.push_back(res);
         end
      end
   endtask

   task automatic checkWb(input string testName, input mipsPkg::regAddr_t gotReg,
                          input mipsPkg::word_t gotData);
      mipsPkg::regAddr_t wantReg;
      mipsPkg::word_t    wantData;
      if (expWbReg.size() == 0) begin
         $display("%s: unexpected extra writeback to r%0d with data %h",
                  testName, gotReg, gotData);
         otherErrors++;
      end else begin
         wantReg = expWbReg.pop_front();
         wantData = expWbData.pop_front();
         if (gotReg !== wantReg) begin
            $display("ERR %s wbReg expected %0d actual %0d", testName, wantReg, gotReg);
            wbErrors++;
         end
         if (gotData !== wantData) begin
            $display("ERR %s wbData r%0d expected %h actual %h",
                     testName, wantReg, wantData, gotData);
            wbErrors++;
         end
      end
   endtask

   task automatic checkStore(input string testName, input mipsPkg::word_t gotAddr,
                             input mipsPkg::word_t gotData);
      mipsPkg::word_t wantAddr;
      mipsPkg::word_t wantData;
      if (expStAddr.size() == 0) begin
         $display("%s: unexpected extra store to address %h", testName, gotAddr);
         otherErrors++;
      end else begin
         wantAddr = expStAddr.pop_front();
         wantData = expStData.pop_front();
         if (gotAddr !== wantAddr) begin
            $display("ERR %s storeAddr expected %h actual %h", testName, wantAddr, gotAddr);
            storeErrors++;
         end
         if (gotData !== wantData) begin
            $display("ERR %s storeData expected %h actual %h", testName, wantData, gotData);
            storeErrors++;
         end
      end
   endtask

   // Whole memory rewritten, tail padded with nop words
   task automatic loadProgram();
      run <= 1'b0;
      for (int i = 0; i < imemWords; i++) begin
         progWe   <= 1'b1;
         progAddr <= i;
         progData <= (i < prog.size()) ? prog[i] : '0;
         @(posedge Clk);
      end
      progWe <= 1'b0;
      // Pipeline restarts from PC zero
      repeat (2) @(posedge Clk);
   endtask

   task automatic runProgram(input string testName);
      int wantWb;
      int wantSt;
      int waited;
      modelRun();
      wantWb = expWbReg.size();
      wantSt = expStAddr.size();
      loadProgram();
      gotWbReg.delete();
      gotWbData.delete();
      gotStAddr.delete();
      gotStData.delete();
      run <= 1'b1;
      waited = 0;
      while ((gotWbReg.size() < wantWb || gotStAddr.size() < wantSt) &&
             waited < retireWindow) begin
         @(posedge Clk);
         waited++;
      end
      // Short window to catch anything that should not retire
      repeat (extraWindow) @(posedge Clk);
      run <= 1'b0;
      while (gotWbReg.size() > 0) begin
         checkWb(testName, gotWbReg.pop_front(), gotWbData.pop_front());
      end
      while (gotStAddr.size() > 0) begin
         checkStore(testName, gotStAddr.pop_front(), gotStData.pop_front());
      end
      if (expWbReg.size() != 0) begin
         $display("%s: %0d expected writebacks never appeared", testName, expWbReg.size());
         otherErrors++;
      end
      if (expStAddr.size() != 0) begin
         $display("%s: %0d expected stores never appeared", testName, expStAddr.size());
         otherErrors++;
      end
      expWbReg.delete();
      expWbData.delete();
      expStAddr.delete();
      expStData.delete();
   endtask

   task automatic aluOpsTest();
      prog.delete();
      emitI(mipsPkg::opAddi, 5'd1, 5'd0, 16'd5);
      emitNops(3);
      emitI(mipsPkg::opAddi, 5'd2, 5'd0, 16'hfffd);
      emitNops(3);
      emitR(mipsPkg::fnAdd, 5'd3, 5'd1, 5'd2);
      emitR(mipsPkg::fnSub, 5'd4, 5'd1, 5'd2);
      emitR(mipsPkg::fnAnd, 5'd5, 5'd1, 5'd2);
      emitR(mipsPkg::fnOr, 5'd6, 5'd1, 5'd2);
      // Negative against positive both ways
      emitR(mipsPkg::fnSlt, 5'd7, 5'd2, 5'd1);
      emitR(mipsPkg::fnSlt, 5'd8, 5'd1, 5'd2);
      runProgram("aluOps");
   endtask

   task automatic forwardTest();
      prog.delete();
      emitI(mipsPkg::opAddi, 5'd1, 5'd0, 16'd7);
      // A from MEM
      emitI(mipsPkg::opAddi, 5'd2, 5'd1, 16'd3);
      // A from MEM, B from WB
      emitR(mipsPkg::fnAdd, 5'd3, 5'd2, 5'd1);
      // r1 three back through the register file, B from MEM
      emitR(mipsPkg::fnSub, 5'd4, 5'd1, 5'd3);
      emitR(mipsPkg::fnAnd, 5'd5, 5'd4, 5'd4);
      emitR(mipsPkg::fnOr, 5'd6, 5'd2, 5'd5);
      // A from WB, B from MEM
      emitR(mipsPkg::fnAdd, 5'd7, 5'd5, 5'd6);
      runProgram("forward");
   endtask

   task automatic loadStoreTest();
      prog.delete();
      emitI(mipsPkg::opAddi, 5'd1, 5'd0, 16'd16);
      emitI(mipsPkg::opAddi, 5'd2, 5'd0, 16'h1234);
      emitI(mipsPkg::opSw, 5'd2, 5'd1, 16'd4);
      emitI(mipsPkg::opLw, 5'd3, 5'd1, 16'd4);
      // Load-use, one bubble
      emitR(mipsPkg::fnAdd, 5'd4, 5'd3, 5'd1);
      // Store data forwarded from MEM
      emitI(mipsPkg::opSw, 5'd4, 5'd1, 16'd8);
      emitI(mipsPkg::opLw, 5'd5, 5'd1, 16'd8);
      emitR(mipsPkg::fnAdd, 5'd6, 5'd5, 5'd5);
      runProgram("loadStore");
   endtask

   task automatic branchTest();
      prog.delete();
      emitI(mipsPkg::opAddi, 5'd1, 5'd0, 16'd3);
      emitI(mipsPkg::opAddi, 5'd2, 5'd0, 16'd3);
      emitI(mipsPkg::opBeq, 5'd2, 5'd1, 16'd2);
      // Squashed pair
      emitI(mipsPkg::opAddi, 5'd3, 5'd0, 16'd100);
      emitI(mipsPkg::opAddi, 5'd4, 5'd0, 16'd101);
      emitI(mipsPkg::opAddi, 5'd5, 5'd0, 16'd55);
      // Not taken
      emitI(mipsPkg::opBeq, 5'd5, 5'd1, 16'd1);
      emitI(mipsPkg::opAddi, 5'd6, 5'd0, 16'd66);
      emitI(mipsPkg::opAddi, 5'd8, 5'd0, 16'd6);
      emitR(mipsPkg::fnAdd, 5'd7, 5'd1, 5'd2);
      // Operands from MEM and WB
      emitI(mipsPkg::opBeq, 5'd8, 5'd7, 16'd2);
      emitI(mipsPkg::opAddi, 5'd9, 5'd0, 16'd88);
      emitI(mipsPkg::opAddi, 5'd10, 5'd0, 16'd99);
      emitI(mipsPkg::opAddi, 5'd11, 5'd0, 16'd77);
      runProgram("branch");
   endtask

   task automatic randomTest();
      logic [31:0] r;
      prog.delete();
      for (int i = 0; i < 30; i++) begin
         rngState = xorshift32(rngState);
         r = rngState;
         case (r[31:24] % 8'd6)
            8'd0: emitI(mipsPkg::opAddi, regPick(r[7:0]), regPick(r[15:8]), r[23:8]);
            8'd1: emitR(mipsPkg::fnAdd, regPick(r[7:0]), regPick(r[15:8]), regPick(r[23:16]));
            8'd2: emitR(mipsPkg::fnSub, regPick(r[7:0]), regPick(r[15:8]), regPick(r[23:16]));
            8'd3: emitR(mipsPkg::fnAnd, regPick(r[7:0]), regPick(r[15:8]), regPick(r[23:16]));
            8'd4: emitR(mipsPkg::fnOr, regPick(r[7:0]), regPick(r[15:8]), regPick(r[23:16]));
            default: emitR(mipsPkg::fnSlt, regPick(r[7:0]), regPick(r[15:8]),
                           regPick(r[23:16]));
         endcase
      end
      runProgram("random");
   endtask

   initial begin
      Clk = 1'b0;
      arstN = 1'b0;
      run = 1'b0;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      wbErrors = 0;
      storeErrors = 0;
      otherErrors = 0;
      rngState = 32'd39;
      for (int i = 0; i < 32; i++) modelRegs[i] = '0;
      for (int i = 0; i < dmemWords; i++) modelMem[i] = '0;
      repeat (4) @(posedge Clk);
      arstN <= 1'b1;
      @(posedge Clk);
      aluOpsTest();
      forwardTest();
      loadStoreTest();
      branchTest();
      randomTest();
      $display("Errors: writeback %0d, store %0d, other %0d",
               wbErrors, storeErrors, otherErrors);
      if (wbErrors + storeErrors + otherErrors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Hang guard
   initial begin
      repeat (watchdogCycles) @(posedge Clk);
      $display("Watchdog expired after %0d cycles, the tests did not finish", watchdogCycles);
      $display("Verification failed");
      $finish;
   end

endmodule

/* compile.f */
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mips32.sv
tests/mips32_checker.sv
tests/mips32Tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mips32Tb
FILELIST = compile.f
LOG      = sim.log
FAILMSG  = Verification failed
PASSMSG  = Verification passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build directory and $(LOG)"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
